// File: vlog.f
+incdir+source
+incdir+testbench
source/id_pkg.sv
source/id_ctrl_if.sv
source/reg_file.sv
source/control_decoder.sv
source/hazard_unit.sv
source/id_stage.sv
testbench/tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - include_dirs:
      - source
    files:
      - source/id_pkg.sv
      - source/id_ctrl_if.sv
      - source/reg_file.sv
      - source/control_decoder.sv
      - source/hazard_unit.sv
      - source/id_stage.sv
  - target: test
    include_dirs:
      - source
      - testbench
    files:
      - testbench/tb_id_stage.sv

// File: testbench/tb_id_vectors.svh
// Directed steps for tb_id_stage; expected values already hold the bubble, write data is random
`ifndef TB_ID_VECTORS_SVH
`define TB_ID_VECTORS_SVH

// One directed step
typedef struct packed {
    logic            wb_en;     // Write-back enable
    logic [3:0]      wb_idx;
    id_pkg::opcode_e op;
    logic [3:0]      rs;
    logic [3:0]      rt;
    logic [3:0]      ls_reg;    // Load/save register field
    logic [3:0]      aimm;
    logic [7:0]      lsimm;
    logic [3:0]      id_ex;     // In-flight destinations
    logic [3:0]      ex_mem;
    logic [3:0]      mem_wb;
    logic            pc_haz_in;
    logic            pc_upd;
    // Grouped as {reg_write, mem_write, mem_read, mem_to_reg, alu_src}
    // then {branch, call, ret} then {load_half, half_spec, halt}
    logic [10:0]     exp_ctrl;
    id_pkg::alu_op_e exp_alu;
    logic [15:0]     exp_sext;
    logic            exp_dhaz;
} vec_t;

localparam int VEC_N = 32;

vec_t vecs [0:VEC_N-1];

// Columns per row: wb_en, wb_idx, op, rs, rt, ls_reg, aimm, lsimm,
// id_ex, ex_mem, mem_wb, pc_haz_in, pc_upd, then ctrl, alu_op, sign_ext_out, data_hazard
task automatic fill_vectors();
    vecs[0]  = '{0, 0, id_pkg::CALL, 3, 4, 5, 'h1, 'h10, 0, 0, 0, 0, 0,
                 'b00000_010_000, id_pkg::ALU_ADD, 'h0001, 0}; // R15 from reset
    vecs[1]  = '{1, 1, id_pkg::ADD, 1, 2, 5, 'h7, 'h10, 0, 0, 0, 0, 1,
                 'b10000_000_000, id_pkg::ALU_ADD, 'h0007, 0}; // Reads R1 while writing it
    vecs[2]  = '{1, 0, id_pkg::SUB, 1, 3, 5, 'h8, 'h10, 0, 0, 0, 0, 0,
                 'b10000_000_000, id_pkg::ALU_SUB, 'hFFF8, 0}; // Write to R0 dropped
    vecs[3]  = '{0, 0, id_pkg::AND, 0, 4, 5, 'hF, 'h10, 0, 0, 0, 0, 0,
                 'b10000_000_000, id_pkg::ALU_AND, 'hFFFF, 0};
    vecs[4]  = '{0, 0, id_pkg::OR, 4, 5, 5, 'h0, 'h10, 0, 0, 0, 0, 0,
                 'b10000_000_000, id_pkg::ALU_OR, 'h0000, 0};
    vecs[5]  = '{0, 0, id_pkg::SLL, 6, 7, 5, 'h3, 'h10, 0, 0, 0, 0, 0,
                 'b10000_000_000, id_pkg::ALU_SLL, 'h0003, 0};
    vecs[6]  = '{0, 0, id_pkg::SRL, 8, 9, 5, 'hC, 'h10, 0, 0, 0, 0, 0,
                 'b10000_000_000, id_pkg::ALU_SRL, 'hFFFC, 0};
    vecs[7]  = '{0, 0, id_pkg::ADDI, 10, 11, 5, 'h9, 'h10, 0, 0, 0, 0, 0,
                 'b10001_000_000, id_pkg::ALU_ADD, 'hFFF9, 0};
    vecs[8]  = '{0, 0, id_pkg::SUBI, 12, 11, 5, 'h5, 'h10, 0, 0, 0, 0, 0,
                 'b10001_000_000, id_pkg::ALU_SUB, 'h0005, 0};
    vecs[9]  = '{0, 0, id_pkg::LW, 3, 4, 5, 'h1, 'h80, 0, 0, 0, 0, 0,
                 'b10111_000_000, id_pkg::ALU_ADD, 'hFF80, 0}; // Base R14
    vecs[10] = '{0, 0, id_pkg::SW, 3, 4, 6, 'h1, 'h7F, 0, 0, 0, 0, 0,
                 'b01001_000_000, id_pkg::ALU_ADD, 'h007F, 0};
    vecs[11] = '{0, 0, id_pkg::LHB, 3, 4, 7, 'h1, 'hA5, 0, 0, 0, 0, 0,
                 'b10000_000_100, id_pkg::ALU_PASS, 'hFFA5, 0};
    vecs[12] = '{0, 0, id_pkg::LLB, 3, 4, 13, 'h1, 'h5A, 0, 0, 0, 0, 0,
                 'b10000_000_110, id_pkg::ALU_PASS, 'h005A, 0};
    vecs[13] = '{0, 0, id_pkg::B, 3, 4, 5, 'hA, 'h10, 0, 0, 0, 0, 0,
                 'b00000_100_000, id_pkg::ALU_ADD, 'hFFFA, 0};
    vecs[14] = '{0, 0, id_pkg::RET, 3, 4, 5, 'h2, 'h10, 0, 0, 0, 0, 0,
                 'b00000_001_000, id_pkg::ALU_ADD, 'h0002, 0};
    vecs[15] = '{0, 0, id_pkg::HLT, 3, 4, 5, 'hB, 'h10, 0, 0, 0, 0, 1,
                 'b00000_000_001, id_pkg::ALU_ADD, 'hFFFB, 0};
    // Data hazards on each in-flight stage
    vecs[16] = '{0, 0, id_pkg::ADD, 3, 4, 5, 'h6, 'h80, 3, 0, 0, 0, 0,
                 0, id_pkg::ALU_NOP, 'h0006, 1};
    vecs[17] = '{0, 0, id_pkg::ADD, 3, 4, 5, 'h6, 'h80, 0, 4, 0, 0, 0,
                 0, id_pkg::ALU_NOP, 'h0006, 1};
    vecs[18] = '{0, 0, id_pkg::SUB, 5, 6, 5, 'h6, 'h80, 0, 0, 5, 0, 0,
                 0, id_pkg::ALU_NOP, 'h0006, 1};
    vecs[19] = '{0, 0, id_pkg::ADD, 0, 0, 5, 'h6, 'h80, 0, 0, 0, 0, 0,
                 'b10000_000_000, id_pkg::ALU_ADD, 'h0006, 0}; // Index 0 never hazards
    vecs[20] = '{0, 0, id_pkg::ADDI, 2, 9, 5, 'h6, 'h80, 9, 0, 0, 0, 0,
                 'b10001_000_000, id_pkg::ALU_ADD, 'h0006, 0}; // rt unused
    vecs[21] = '{0, 0, id_pkg::B, 7, 8, 5, 'h6, 'h80, 7, 8, 0, 0, 0,
                 'b00000_100_000, id_pkg::ALU_ADD, 'h0006, 0};
    vecs[22] = '{0, 0, id_pkg::SW, 3, 4, 6, 'h6, 'h80, 14, 0, 0, 0, 0,
                 0, id_pkg::ALU_NOP, 'hFF80, 1}; // R14 base in flight
    vecs[23] = '{0, 0, id_pkg::SW, 3, 4, 6, 'h6, 'h80, 0, 6, 0, 0, 0,
                 0, id_pkg::ALU_NOP, 'hFF80, 1};
    vecs[24] = '{0, 0, id_pkg::CALL, 3, 4, 5, 'h6, 'h80, 0, 0, 15, 0, 0,
                 0, id_pkg::ALU_NOP, 'h0006, 1}; // Squashed, no PC hazard
    vecs[25] = '{0, 0, id_pkg::LLB, 3, 4, 7, 'h6, 'h80, 7, 0, 0, 0, 0,
                 0, id_pkg::ALU_NOP, 'hFF80, 1};
    // PC hazard input and flag
    vecs[26] = '{0, 0, id_pkg::ADD, 1, 2, 5, 'h6, 'h80, 0, 0, 0, 1, 0,
                 0, id_pkg::ALU_NOP, 'h0006, 0};
    vecs[27] = '{0, 0, id_pkg::RET, 1, 2, 5, 'h6, 'h80, 0, 0, 0, 1, 0,
                 0, id_pkg::ALU_NOP, 'h0006, 0};
    vecs[28] = '{0, 0, id_pkg::CALL, 1, 2, 5, 'h6, 'h80, 0, 0, 0, 0, 0,
                 'b00000_010_000, id_pkg::ALU_ADD, 'h0006, 0};
    vecs[29] = '{0, 0, id_pkg::ADD, 1, 2, 5, 'h6, 'h80, 0, 0, 0, 0, 0,
                 'b10000_000_000, id_pkg::ALU_ADD, 'h0006, 0};
    vecs[30] = '{0, 0, id_pkg::CALL, 1, 2, 5, 'h6, 'h80, 0, 0, 0, 0, 1,
                 'b00000_010_000, id_pkg::ALU_ADD, 'h0006, 0}; // Update beats new set
    vecs[31] = '{0, 0, id_pkg::B, 1, 2, 5, 'h6, 'h80, 0, 0, 0, 0, 0,
                 'b00000_100_000, id_pkg::ALU_ADD, 'h0006, 0};
endtask

`endif

// File: testbench/tb_id_stage.sv
// Directed table then random register traffic; stops at the first mismatch, needs +incdir for headers
`timescale 1ns/1ps

`include "id_cfg.svh"

module tb_id_stage;

    // DUT inputs
    logic clk, rst, pc_update, pc_hazard_in, reg_write_in;
    logic [`ID_REG_AW-1:0] reg_rs, reg_rt_arith, reg_rd_wb, load_save_reg_in;
    logic [`ID_REG_AW-1:0] id_ex_rd, ex_mem_rd, mem_wb_rd;
    logic [`ID_DATA_W-1:0] reg_rd_data, pc_in;
    id_pkg::opcode_e       opcode;
    logic [2:0]            branch_cond_in;
    logic [3:0]            arith_imm_in;
    logic [7:0]            load_save_imm_in;
    logic [11:0]           call_target_in;

    // DUT outputs
    logic reg_write_out, mem_write_out, mem_read_out, mem_to_reg, alu_src;
    logic branch, call, ret, load_half, half_spec, halt;
    logic data_hazard, pc_hazard_out;
    id_pkg::alu_op_e       alu_op;
    logic [`ID_DATA_W-1:0] read_data_1, read_data_2, pc_out, sign_ext_out;
    logic [2:0]            branch_cond_out;
    logic [3:0]            arith_imm_out, load_save_reg_out;
    logic [7:0]            load_save_imm_out;
    logic [11:0]           call_target_out;

    logic [`ID_DATA_W-1:0] shadow [0:`ID_REG_N-1]; // Register file model
    logic                  exp_pc_haz;             // Control-flow hazard model

    localparam int RAND_N = 200;

    `include "tb_id_vectors.svh"

    id_stage i_id_stage (.*);

    task automatic expect_equal(input string name, input logic [15:0] exp,
                                input logic [15:0] act);
        assert (act === exp) else begin
            $display("FAILED time=%0t ns %s expected=%h actual=%h", $time, name, exp, act);
            $display("Simulation failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // ADD step with random write-back and immediates
    function automatic vec_t make_add_vector(input logic wb_en, input logic [3:0] wb_idx,
                                             input logic [3:0] rs, input logic [3:0] rt);
        vec_t v;
        v          = '0;
        v.wb_en    = wb_en;
        v.wb_idx   = wb_idx;
        v.op       = id_pkg::ADD;
        v.rs       = rs;
        v.rt       = rt;
        v.ls_reg   = 4'($urandom);
        v.aimm     = 4'($urandom);
        v.lsimm    = 8'($urandom);
        v.exp_ctrl = 11'b10000_000_000;
        v.exp_alu  = id_pkg::ALU_ADD;
        v.exp_sext = {{12{v.aimm[3]}}, v.aimm}; // Arithmetic immediate
        return v;
    endfunction

    task automatic apply_vector(input vec_t v);
        logic [`ID_DATA_W-1:0] wdata;
        logic [`ID_DATA_W-1:0] pc;
        logic [2:0]            bcond;
        logic [11:0]           target;
        logic [3:0]            s1;
        logic [3:0]            s2;
        logic                  bub;
        wdata  = 16'($urandom);
        pc     = 16'($urandom);
        bcond  = 3'($urandom);
        target = 12'($urandom);
        @(posedge clk);
        reg_write_in     <= v.wb_en;
        reg_rd_wb        <= v.wb_idx;
        reg_rd_data      <= wdata;
        opcode           <= v.op;
        reg_rs           <= v.rs;
        reg_rt_arith     <= v.rt;
        load_save_reg_in <= v.ls_reg;
        arith_imm_in     <= v.aimm;
        load_save_imm_in <= v.lsimm;
        branch_cond_in   <= bcond;
        call_target_in   <= target;
        pc_in            <= pc;
        id_ex_rd         <= v.id_ex;
        ex_mem_rd        <= v.ex_mem;
        mem_wb_rd        <= v.mem_wb;
        pc_hazard_in     <= v.pc_haz_in;
        pc_update        <= v.pc_upd;
        @(negedge clk);
        bub = v.exp_dhaz || v.pc_haz_in;
        // Source 1 is R14 for LW/SW, R15 for CALL/RET
        if (v.op == id_pkg::LW || v.op == id_pkg::SW)
            s1 = 4'(`ID_DS_REG);
        else if (v.op == id_pkg::CALL || v.op == id_pkg::RET)
            s1 = 4'(`ID_SP_REG);
        else
            s1 = v.rs;
        if (v.op == id_pkg::SW || v.op == id_pkg::LHB || v.op == id_pkg::LLB)
            s2 = v.ls_reg; // Load/save register field
        else
            s2 = v.rt;
        expect_equal("{reg_write_out..halt}", v.exp_ctrl,
                     {reg_write_out, mem_write_out, mem_read_out, mem_to_reg, alu_src,
                      branch, call, ret, load_half, half_spec, halt});
        expect_equal("alu_op", v.exp_alu, alu_op);
        expect_equal("sign_ext_out", v.exp_sext, sign_ext_out);
        expect_equal("data_hazard", v.exp_dhaz, data_hazard);
        expect_equal("pc_hazard_out", exp_pc_haz, pc_hazard_out);
        expect_equal("read_data_1", bub ? 16'h0 : shadow[s1], read_data_1);
        expect_equal("read_data_2", bub ? 16'h0 : shadow[s2], read_data_2);
        expect_equal("pc_out", pc, pc_out); // Never squashed
        expect_equal("branch_cond_out", bub ? 3'h0 : bcond, branch_cond_out);
        expect_equal("arith_imm_out", bub ? 4'h0 : v.aimm, arith_imm_out);
        expect_equal("load_save_reg_out", bub ? 4'h0 : v.ls_reg, load_save_reg_out);
        expect_equal("load_save_imm_out", bub ? 8'h0 : v.lsimm, load_save_imm_out);
        expect_equal("call_target_out", bub ? 12'h0 : target, call_target_out);
        // Models follow the coming edge
        if (v.wb_en && (v.wb_idx != 4'd0))
            shadow[v.wb_idx] = wdata;
        if (v.pc_upd)
            exp_pc_haz = 1'b0;
        else if ((v.op == id_pkg::CALL || v.op == id_pkg::RET) && !bub)
            exp_pc_haz = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    // Watchdog sized from reset, table and random phase
    initial begin
        #((8 + VEC_N + 300) * 4 * 2);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int i;
        void'($urandom(64797));
        fill_vectors();
        rst              = 1'b1;
        pc_update        = 1'b0;
        pc_hazard_in     = 1'b0;
        reg_write_in     = 1'b0;
        reg_rs           = '0;
        reg_rt_arith     = '0;
        reg_rd_wb        = '0;
        reg_rd_data      = '0;
        opcode           = id_pkg::B;
        branch_cond_in   = '0;
        arith_imm_in     = '0;
        load_save_reg_in = '0;
        load_save_imm_in = '0;
        call_target_in   = '0;
        pc_in            = '0;
        id_ex_rd         = '0;
        ex_mem_rd        = '0;
        mem_wb_rd        = '0;
        for (i = 0; i < `ID_REG_N; i++)
            shadow[i] = 'x; // Unknown until written
        shadow[0]  = '0;
        shadow[15] = `ID_SP_RESET;
        exp_pc_haz = 1'b0;

        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Fill R1..R14, reading R15 from reset along the way
        for (i = 1; i < 15; i++)
            apply_vector(make_add_vector(1'b1, 4'(i), 4'd0, 4'd15));

        for (i = 0; i < VEC_N; i++)
            apply_vector(vecs[i]);

        // Random write-back traffic, R0 and same-cycle reads included
        repeat (RAND_N)
            apply_vector(make_add_vector(1'($urandom), 4'($urandom), 4'($urandom),
                                         4'($urandom)));

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: source/id_stage.sv
// Outputs feed the ID/EX register directly; bubble zeroes payload but passes sign_ext_out and pc
`timescale 1ns/1ps

`include "id_cfg.svh"

module id_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pc_update,
    input  logic                   pc_hazard_in,      // Squash request from the PC updater

    // Write-back and register operands
    input  logic                   reg_write_in,
    input  logic [`ID_REG_AW-1:0]  reg_rs,            // Inst[7:4]
    input  logic [`ID_REG_AW-1:0]  reg_rt_arith,      // Inst[3:0]
    input  logic [`ID_REG_AW-1:0]  reg_rd_wb,
    input  logic [`ID_DATA_W-1:0]  reg_rd_data,

    // Instruction fields
    input  id_pkg::opcode_e        opcode,            // Inst[15:12]
    input  logic [2:0]             branch_cond_in,    // Inst[10:8]
    input  logic [`ID_AIMM_W-1:0]  arith_imm_in,
    input  logic [`ID_REG_AW-1:0]  load_save_reg_in,  // Inst[11:8]
    input  logic [`ID_LSIMM_W-1:0] load_save_imm_in,
    input  logic [11:0]            call_target_in,
    input  logic [`ID_DATA_W-1:0]  pc_in,

    // Destinations still in flight
    input  logic [`ID_REG_AW-1:0]  id_ex_rd,
    input  logic [`ID_REG_AW-1:0]  ex_mem_rd,
    input  logic [`ID_REG_AW-1:0]  mem_wb_rd,

    // Control to ID/EX
    output logic                   reg_write_out,
    output logic                   mem_write_out,
    output logic                   mem_read_out,
    output logic                   mem_to_reg,
    output logic                   alu_src,
    output id_pkg::alu_op_e        alu_op,
    output logic                   branch,
    output logic                   call,
    output logic                   ret,
    output logic                   load_half,
    output logic                   half_spec,
    output logic                   halt,

    // Operands and fields to ID/EX
    output logic [`ID_DATA_W-1:0]  read_data_1,
    output logic [`ID_DATA_W-1:0]  read_data_2,
    output logic [2:0]             branch_cond_out,
    output logic [`ID_AIMM_W-1:0]  arith_imm_out,
    output logic [`ID_REG_AW-1:0]  load_save_reg_out,
    output logic [`ID_LSIMM_W-1:0] load_save_imm_out,
    output logic [11:0]            call_target_out,
    output logic [`ID_DATA_W-1:0]  pc_out,
    output logic [`ID_DATA_W-1:0]  sign_ext_out,

    output logic                   data_hazard,
    output logic                   pc_hazard_out
);

    logic [`ID_REG_AW-1:0] src1;      // Effective read indices
    logic [`ID_REG_AW-1:0] src2;
    logic [`ID_DATA_W-1:0] rf_rdata1;
    logic [`ID_DATA_W-1:0] rf_rdata2;
    logic                  rf_we;
    logic [`ID_REG_AW-1:0] rf_waddr;
    logic [`ID_DATA_W-1:0] rf_wdata;
    logic                  bubble;

    id_ctrl_if ctrl_bus ();

    control_decoder i_control_decoder (
        .opcode (opcode),
        .ctrl   (ctrl_bus.dec)
    );

    // Source 1 forcing, data segment before stack pointer
    always_comb begin
        if (ctrl_bus.data_reg) begin
            src1 = `ID_REG_AW'(`ID_DS_REG);
        end else if (ctrl_bus.stack_reg) begin
            src1 = `ID_REG_AW'(`ID_SP_REG);
        end else begin
            src1 = reg_rs;
        end
    end

    assign src2 = ctrl_bus.rt_src ? load_save_reg_in : reg_rt_arith; // SW and half loads

    // Reset owns the write port to seed the stack pointer
    assign rf_we    = rst ? 1'b1 : reg_write_in;
    assign rf_waddr = rst ? `ID_REG_AW'(`ID_SP_REG) : reg_rd_wb;
    assign rf_wdata = rst ? `ID_SP_RESET : reg_rd_data;

    reg_file i_reg_file (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (src1),
        .raddr2 (src2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    assign bubble = data_hazard || pc_hazard_in;

    hazard_unit i_hazard_unit (
        .clk         (clk),
        .rst         (rst),
        .pc_update   (pc_update),
        .bubble      (bubble),
        .src1        (src1),
        .src2        (src2),
        .ld_sv_reg   (load_save_reg_in),
        .id_ex_rd    (id_ex_rd),
        .ex_mem_rd   (ex_mem_rd),
        .mem_wb_rd   (mem_wb_rd),
        .ctrl        (ctrl_bus.haz),
        .data_hazard (data_hazard),
        .pc_hazard   (pc_hazard_out)
    );

    // Sign extension
    always_comb begin
        if (ctrl_bus.sign_ext_sel) begin
            sign_ext_out = {{(`ID_DATA_W - `ID_LSIMM_W){load_save_imm_in[`ID_LSIMM_W-1]}},
                            load_save_imm_in};
        end else begin
            sign_ext_out = {{(`ID_DATA_W - `ID_AIMM_W){arith_imm_in[`ID_AIMM_W-1]}},
                            arith_imm_in};
        end
    end

    assign pc_out = pc_in; // Never squashed

    // Bubble mux
    always_comb begin
        if (bubble) begin
            reg_write_out     = 1'b0;
            mem_write_out     = 1'b0;
            mem_read_out      = 1'b0;
            mem_to_reg        = 1'b0;
            alu_src           = 1'b0;
            alu_op            = id_pkg::ALU_NOP;
            branch            = 1'b0;
            call              = 1'b0;
            ret               = 1'b0;
            load_half         = 1'b0;
            half_spec         = 1'b0;
            halt              = 1'b0;
            read_data_1       = '0;
            read_data_2       = '0;
            branch_cond_out   = '0;
            arith_imm_out     = '0;
            load_save_reg_out = '0; // Also clears the destination
            load_save_imm_out = '0;
            call_target_out   = '0;
        end else begin
            reg_write_out     = ctrl_bus.reg_write;
            mem_write_out     = ctrl_bus.mem_write;
            mem_read_out      = ctrl_bus.mem_read;
            mem_to_reg        = ctrl_bus.mem_to_reg;
            alu_src           = ctrl_bus.alu_src;
            alu_op            = ctrl_bus.alu_op;
            branch            = ctrl_bus.branch;
            call              = ctrl_bus.call;
            ret               = ctrl_bus.ret;
            load_half         = ctrl_bus.load_half;
            half_spec         = ctrl_bus.half_spec;
            halt              = ctrl_bus.halt;
            read_data_1       = rf_rdata1;
            read_data_2       = rf_rdata2;
            branch_cond_out   = branch_cond_in;
            arith_imm_out     = arith_imm_in;
            load_save_reg_out = load_save_reg_in;
            load_save_imm_out = load_save_imm_in;
            call_target_out   = call_target_in;
        end
    end

    // No memory access may leak past a squash
    a_bubble_no_mem: assert property (@(posedge clk)
        bubble |-> (!mem_write_out && !mem_read_out));

endmodule

// File: source/hazard_unit.sv
// Destination 0 means no write in flight; pc_hazard lags the call/ret decode by one cycle
`timescale 1ns/1ps

`include "id_cfg.svh"

module hazard_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pc_update,   // One-cycle pulse from the PC updater
    input  logic                  bubble,      // Current instruction is being squashed
    input  logic [`ID_REG_AW-1:0] src1,        // Effective index after R14/R15 forcing
    input  logic [`ID_REG_AW-1:0] src2,
    input  logic [`ID_REG_AW-1:0] ld_sv_reg,
    input  logic [`ID_REG_AW-1:0] id_ex_rd,
    input  logic [`ID_REG_AW-1:0] ex_mem_rd,
    input  logic [`ID_REG_AW-1:0] mem_wb_rd,
    id_ctrl_if.haz                ctrl,
    output logic                  data_hazard,
    output logic                  pc_hazard
);

    // Nonzero index still owed by EX, MEM or WB
    function automatic logic in_flight(input logic [`ID_REG_AW-1:0] idx);
        return (idx != '0) && ((idx == id_ex_rd) || (idx == ex_mem_rd) || (idx == mem_wb_rd));
    endfunction

    // WB included since the register file has no bypass
    always_comb begin
        data_hazard = (ctrl.uses_rs && in_flight(src1)) ||
                      (ctrl.uses_rt && in_flight(src2)) ||
                      (ctrl.uses_rd && in_flight(ld_sv_reg));
    end

    // Control-flow hazard held until the PC has been redirected
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_hazard <= 1'b0;
        end else if (pc_update) begin
            pc_hazard <= 1'b0; // Wins over a new call/ret
        end else if ((ctrl.call || ctrl.ret) && !bubble) begin
            pc_hazard <= 1'b1;
        end
    end

    a_pc_hazard_reset: assert property (@(posedge clk) rst |=> !pc_hazard);

    a_pc_hazard_clear: assert property (@(posedge clk) pc_update |=> !pc_hazard);

    // Stage index select has to agree with the decoder
    a_ds_base: assert property (@(posedge clk) disable iff (rst)
        ctrl.data_reg |-> (src1 == `ID_REG_AW'(`ID_DS_REG)));

endmodule

// File: source/control_decoder.sv
// Purely combinational; every opcode value is decoded, no illegal encodings exist
`timescale 1ns/1ps

module control_decoder (
    input  id_pkg::opcode_e opcode,
    id_ctrl_if.dec          ctrl
);

    always_comb begin
        // Everything idle unless the opcode says otherwise
        ctrl.reg_write    = 1'b0;
        ctrl.mem_write    = 1'b0;
        ctrl.mem_read     = 1'b0;
        ctrl.mem_to_reg   = 1'b0;
        ctrl.alu_src      = 1'b0;
        ctrl.alu_op       = id_pkg::ALU_ADD;
        ctrl.branch       = 1'b0;
        ctrl.call         = 1'b0;
        ctrl.ret          = 1'b0;
        ctrl.load_half    = 1'b0;
        ctrl.half_spec    = 1'b0;
        ctrl.sign_ext_sel = 1'b0;
        ctrl.rt_src       = 1'b0;
        ctrl.data_reg     = 1'b0;
        ctrl.stack_reg    = 1'b0;
        ctrl.uses_rs      = 1'b0;
        ctrl.uses_rt      = 1'b0;
        ctrl.uses_rd      = 1'b0;
        ctrl.halt         = 1'b0;

        case (opcode)
            id_pkg::ADD, id_pkg::SUB, id_pkg::AND,
            id_pkg::OR, id_pkg::SLL, id_pkg::SRL: begin
                ctrl.reg_write = 1'b1;
                ctrl.uses_rs   = 1'b1;
                ctrl.uses_rt   = 1'b1;
                // Low three opcode bits line up with the ALU encoding
                ctrl.alu_op    = id_pkg::alu_op_e'(opcode[2:0]);
            end
            id_pkg::ADDI, id_pkg::SUBI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1; // Arithmetic immediate keeps sign_ext_sel at 0
                ctrl.uses_rs   = 1'b1;
                ctrl.alu_op    = (opcode == id_pkg::ADDI) ? id_pkg::ALU_ADD : id_pkg::ALU_SUB;
            end
            id_pkg::LW: begin
                ctrl.data_reg     = 1'b1; // R14 + imm
                ctrl.mem_read     = 1'b1;
                ctrl.mem_to_reg   = 1'b1;
                ctrl.reg_write    = 1'b1;
                ctrl.alu_src      = 1'b1;
                ctrl.sign_ext_sel = 1'b1;
            end
            id_pkg::SW: begin
                ctrl.data_reg     = 1'b1;
                ctrl.rt_src       = 1'b1; // Store data from load_save_reg
                ctrl.mem_write    = 1'b1;
                ctrl.alu_src      = 1'b1;
                ctrl.sign_ext_sel = 1'b1;
                ctrl.uses_rs      = 1'b1;
                ctrl.uses_rd      = 1'b1;
            end
            id_pkg::LHB, id_pkg::LLB: begin
                ctrl.load_half    = 1'b1;
                ctrl.reg_write    = 1'b1;
                ctrl.alu_op       = id_pkg::ALU_PASS;
                ctrl.sign_ext_sel = 1'b1;
                ctrl.half_spec    = (opcode == id_pkg::LLB);
                ctrl.rt_src       = 1'b1; // Old destination keeps the other byte
                ctrl.uses_rd      = 1'b1;
            end
            id_pkg::B: begin
                ctrl.branch = 1'b1; // Reads no register
            end
            id_pkg::CALL: begin
                ctrl.stack_reg = 1'b1;
                ctrl.call      = 1'b1;
                ctrl.uses_rs   = 1'b1;
            end
            id_pkg::RET: begin
                ctrl.stack_reg = 1'b1;
                ctrl.ret       = 1'b1;
                ctrl.uses_rs   = 1'b1;
            end
            id_pkg::HLT: begin
                ctrl.halt = 1'b1;
            end
        endcase
    end

    // Halt must not retire a write
    a_halt_no_write: assert final (!(ctrl.halt && (ctrl.reg_write || ctrl.mem_write)));

endmodule

// File: source/reg_file.sv
// No write-to-read bypass: a same-cycle read returns the old value; R0 is hardwired to zero
`timescale 1ns/1ps

`include "id_cfg.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  we,
    input  logic [`ID_REG_AW-1:0] waddr,
    input  logic [`ID_DATA_W-1:0] wdata,
    input  logic [`ID_REG_AW-1:0] raddr1,
    input  logic [`ID_REG_AW-1:0] raddr2,
    output logic [`ID_DATA_W-1:0] rdata1,
    output logic [`ID_DATA_W-1:0] rdata2
);

    // R1..R15 only, R0 has no storage
    logic [`ID_DATA_W-1:0] regs [1:`ID_REG_N-1];

    // Single write port
    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin // Writes to R0 dropped
            regs[waddr] <= wdata;
        end
    end

    // Asynchronous reads
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end

        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

    // Zero register on both ports
    a_r0_reads_zero: assert property (
        @(posedge clk)
        ((raddr1 == '0) |-> (rdata1 == '0)) and ((raddr2 == '0) |-> (rdata2 == '0))
    );

endmodule

// File: source/id_ctrl_if.sv
// Decoded control bundle; all signals are combinational from the current opcode
`timescale 1ns/1ps

interface id_ctrl_if;

    // Pipeline controls
    logic              reg_write;
    logic              mem_write;
    logic              mem_read;
    logic              mem_to_reg;   // Write back from memory
    logic              alu_src;      // Immediate operand
    id_pkg::alu_op_e   alu_op;
    logic              branch;
    logic              call;
    logic              ret;
    logic              load_half;
    logic              half_spec;    // 0 LHB, 1 LLB

    // Decode stage internal selects
    logic              sign_ext_sel; // 1 picks the load/save immediate
    logic              rt_src;       // Source 2 from load_save_reg
    logic              data_reg;     // Source 1 forced to R14
    logic              stack_reg;    // Source 1 forced to R15

    // Operand usage for hazard checks
    logic              uses_rs;      // Effective source 1
    logic              uses_rt;      // Arithmetic rt field
    logic              uses_rd;      // Load/save register field read as source
    logic              halt;

    modport dec (
        output reg_write, mem_write, mem_read, mem_to_reg, alu_src, alu_op,
        output branch, call, ret, load_half, half_spec,
        output sign_ext_sel, rt_src, data_reg, stack_reg,
        output uses_rs, uses_rt, uses_rd, halt
    );

    modport stage (
        input reg_write, mem_write, mem_read, mem_to_reg, alu_src, alu_op,
        input branch, call, ret, load_half, half_spec,
        input sign_ext_sel, rt_src, data_reg, stack_reg,
        input uses_rs, uses_rt, uses_rd, halt
    );

    modport haz (
        input call, ret, uses_rs, uses_rt, uses_rd, data_reg
    );

endinterface

// File: source/id_pkg.sv
// Opcode values are the ISA encoding of Inst[15:12]; alu_op 7 is reserved for the bubble
package id_pkg;

    // Instruction opcodes
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        SLL  = 4'd4,
        SRL  = 4'd5,
        ADDI = 4'd6,
        SUBI = 4'd7,
        LW   = 4'd8,  // Base is R14
        SW   = 4'd9,  // Base is R14
        LHB  = 4'd10, // Load high byte
        LLB  = 4'd11, // Load low byte
        B    = 4'd12, // Conditional branch
        CALL = 4'd13, // Uses R15
        RET  = 4'd14, // Uses R15
        HLT  = 4'd15
    } opcode_e;

    // ALU operation handed to EX
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_SLL  = 3'd4,
        ALU_SRL  = 3'd5,
        ALU_PASS = 3'd6, // Half-word loads
        ALU_NOP  = 3'd7  // Bubble value
    } alu_op_e;

endpackage

// File: source/id_cfg.svh
// Sizes fixed for a 16-register 16-bit core; index width must stay log2 of the register count
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// Datapath word width
`define ID_DATA_W 16

// Register file geometry
`define ID_REG_N 16
`define ID_REG_AW 4 // Index width, log2 of ID_REG_N

// Special purpose registers
`define ID_SP_REG 15 // Stack pointer
`define ID_DS_REG 14 // Data segment, base for LW and SW

// Stack pointer value loaded while rst is high
`define ID_SP_RESET {`ID_DATA_W{1'b1}}

// Immediate fields taken from the IF/ID register
`define ID_AIMM_W 4  // Arithmetic immediate, Inst[3:0]
`define ID_LSIMM_W 8 // Load/save immediate, Inst[7:0]

`endif
